// File: cpu_mem.f
rtl/cpu_mem_pkg.sv
rtl/cache_bram.sv
rtl/cpu_dcache.sv
rtl/cpu_icache.sv
rtl/cpu_bus_arbiter.sv
rtl/cpu_mem_top.sv
tb/cpu_mem_assert.sv
tb/tb_cpu_mem.sv

// File: rtl/cache_bram.sv
`default_nettype none

module cache_bram import cpu_mem_pkg::*; #(
	parameter int WIDTH      = $bits(entry_t),
	parameter int DEPTH_BITS = 4
) (
	input  wire                  i_clock,
	input  wire                  i_we,
	input  wire [DEPTH_BITS-1:0] i_address,
	input  wire entry_t          i_wdata,
	output entry_t               o_rdata
);

	logic [WIDTH-1:0] mem [0:(1 << DEPTH_BITS) - 1];

	// Registered read, a write shows up on the output the next cycle
	always_ff @(posedge i_clock) begin
		if (i_we) begin
			mem[i_address] <= i_wdata;
			o_rdata <= i_wdata;
		end else begin
			o_rdata <= mem[i_address];
		end
	end

endmodule

`default_nettype wire

// File: rtl/cpu_bus_arbiter.sv
`default_nettype none

module cpu_bus_arbiter import cpu_mem_pkg::*; (
	input  wire         i_clock,
	input  wire         i_rst,

	// Data cache port
	input  wire         i_d_request,
	input  wire         i_d_rw,
	input  wire addr_t  i_d_address,
	input  wire word_t  i_d_wdata,
	output logic        o_d_ready,

	// Instruction cache port
	input  wire         i_i_request,
	input  wire addr_t  i_i_address,
	output logic        o_i_ready,

	// Memory bus
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output addr_t       o_bus_address,
	output word_t       o_bus_wdata,
	input  wire         i_bus_ready
);

	typedef enum logic [1:0] {
		OWN_NONE,
		OWN_DATA,
		OWN_INST
	} owner_t;

	owner_t owner;
	owner_t grant;

	// Owner keeps the bus while its request holds, so a chained
	// write-back and refill cannot be split
	always_comb begin
		if (owner == OWN_DATA && i_d_request) begin
			grant = OWN_DATA;
		end else if (owner == OWN_INST && i_i_request) begin
			grant = OWN_INST;
		end else if (i_d_request) begin
			grant = OWN_DATA;
		end else if (i_i_request) begin
			grant = OWN_INST;
		end else begin
			grant = OWN_NONE;
		end
	end

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			owner <= OWN_NONE;
		end else begin
			owner <= grant;
		end
	end

	// Instruction side only ever reads
	assign o_bus_request = (grant != OWN_NONE);
	assign o_bus_rw      = (grant == OWN_DATA) ? i_d_rw : 1'b0;
	assign o_bus_address = (grant == OWN_INST) ? i_i_address : i_d_address;
	assign o_bus_wdata   = (grant == OWN_DATA) ? i_d_wdata : '0;

	assign o_d_ready = i_bus_ready && (grant == OWN_DATA);
	assign o_i_ready = i_bus_ready && (grant == OWN_INST);

endmodule

`default_nettype wire

// File: rtl/cpu_dcache.sv
`default_nettype none

module cpu_dcache import cpu_mem_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input  wire         i_clock,
	input  wire         i_rst,

	// CPU side
	input  wire         i_request,
	input  wire         i_rw,
	input  wire         i_flush,
	input  wire         i_cacheable,
	input  wire addr_t  i_address,
	input  wire word_t  i_wdata,
	output logic        o_ready,
	output word_t       o_rdata,

	// Bus side
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output addr_t       o_bus_address,
	output word_t       o_bus_wdata,
	input  wire word_t  i_bus_rdata,
	input  wire         i_bus_ready
);

	typedef enum logic [3:0] {
		ST_INITIALIZE,
		ST_IDLE,
		ST_FLUSH_SETUP,
		ST_FLUSH_CHECK,
		ST_FLUSH_WRITE,
		ST_PASS_THROUGH,
		ST_WRITE_SETUP,
		ST_WRITE_WAIT,
		ST_READ_SETUP,
		ST_READ_WB_WAIT,
		ST_READ_BUS_WAIT
	} state_t;

	state_t state;
	state_t next_state;

	// Shared by the init sweep and the flush walk, top bit marks the end of a flush
	logic [INDEX_BITS:0] sweep_index;
	logic [INDEX_BITS:0] next_sweep_index;

	logic                  cache_we;
	logic [INDEX_BITS-1:0] cache_address;
	entry_t                cache_wdata;
	entry_t                cache_rdata;

	cache_bram #(
		.WIDTH      ($bits(entry_t)),
		.DEPTH_BITS (INDEX_BITS)
	) bram0 (
		.i_clock   (i_clock),
		.i_we      (cache_we),
		.i_address (cache_address),
		.i_wdata   (cache_wdata),
		.o_rdata   (cache_rdata)
	);

	logic  entry_valid;
	logic  entry_dirty;
	addr_t entry_addr;
	word_t entry_word;
	logic  addr_match;

	assign entry_valid = cache_rdata[ENTRY_VALID_BIT];
	assign entry_dirty = cache_rdata[ENTRY_DIRTY_BIT];
	assign entry_addr  = entry_address(cache_rdata);
	assign entry_word  = entry_data(cache_rdata);
	assign addr_match  = (entry_addr[31:2] == i_address[31:2]);

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_INITIALIZE;
			sweep_index <= '0;
		end else begin
			state <= next_state;
			sweep_index <= next_sweep_index;
		end
	end

	always_comb begin
		next_state = state;
		next_sweep_index = sweep_index;
		cache_we = 1'b0;
		cache_address = i_address[INDEX_BITS+1:2];
		cache_wdata = ENTRY_INVALID;
		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_request = 1'b0;
		o_bus_rw = 1'b0;
		o_bus_address = '0;
		o_bus_wdata = '0;

		case (state)
			// ==================================================================
			// Init sweep and dispatch
			// ==================================================================
			ST_INITIALIZE: begin
				cache_we = 1'b1;
				cache_address = sweep_index[INDEX_BITS-1:0];
				if (sweep_index[INDEX_BITS-1:0] == '1) begin
					next_sweep_index = '0;
					next_state = ST_IDLE;
				end else begin
					next_sweep_index = sweep_index + 1'b1;
				end
			end

			ST_IDLE: begin
				if (i_request) begin
					if (i_flush) begin
						next_sweep_index = '0;
						next_state = ST_FLUSH_SETUP;
					end else if (!i_cacheable) begin
						next_state = ST_PASS_THROUGH;
					end else if (i_rw) begin
						next_state = ST_WRITE_SETUP;
					end else begin
						next_state = ST_READ_SETUP;
					end
				end
			end

			// ==================================================================
			// Flush, one index at a time
			// ==================================================================
			ST_FLUSH_SETUP: begin
				cache_address = sweep_index[INDEX_BITS-1:0];
				if (sweep_index[INDEX_BITS]) begin
					o_ready = 1'b1;
					next_sweep_index = '0;
					next_state = ST_IDLE;
				end else begin
					next_state = ST_FLUSH_CHECK;
				end
			end

			ST_FLUSH_CHECK: begin
				cache_address = sweep_index[INDEX_BITS-1:0];
				if (entry_dirty) begin
					next_state = ST_FLUSH_WRITE;
				end else begin
					next_sweep_index = sweep_index + 1'b1;
					next_state = ST_FLUSH_SETUP;
				end
			end

			ST_FLUSH_WRITE: begin
				cache_address = sweep_index[INDEX_BITS-1:0];
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_addr;
				o_bus_wdata = entry_word;
				if (i_bus_ready) begin
					// Line stays valid, only dirty drops
					cache_we = 1'b1;
					cache_wdata = make_entry(entry_word, entry_addr, 1'b0);
					next_sweep_index = sweep_index + 1'b1;
					next_state = ST_FLUSH_SETUP;
				end
			end

			// Uncached access goes straight to the bus
			ST_PASS_THROUGH: begin
				o_bus_request = 1'b1;
				o_bus_rw = i_rw;
				o_bus_address = i_address;
				o_bus_wdata = i_wdata;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			// ==================================================================
			// Cached write
			// ==================================================================
			ST_WRITE_SETUP: begin
				if (entry_dirty && !addr_match) begin
					next_state = ST_WRITE_WAIT;
				end else begin
					cache_we = 1'b1;
					cache_wdata = make_entry(i_wdata, i_address, 1'b1);
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			// Old line goes out before the new word lands
			ST_WRITE_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_addr;
				o_bus_wdata = entry_word;
				if (i_bus_ready) begin
					cache_we = 1'b1;
					cache_wdata = make_entry(i_wdata, i_address, 1'b1);
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			// ==================================================================
			// Cached read
			// ==================================================================
			ST_READ_SETUP: begin
				if (entry_valid && addr_match) begin
					o_rdata = entry_word;
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end else if (entry_dirty) begin
					next_state = ST_READ_WB_WAIT;
				end else begin
					next_state = ST_READ_BUS_WAIT;
				end
			end

			ST_READ_WB_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_rw = 1'b1;
				o_bus_address = entry_addr;
				o_bus_wdata = entry_word;
				if (i_bus_ready) begin
					// Chain the refill, request stays high
					o_bus_rw = 1'b0;
					o_bus_address = i_address;
					next_state = ST_READ_BUS_WAIT;
				end
			end

			ST_READ_BUS_WAIT: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					cache_we = 1'b1;
					cache_wdata = make_entry(i_bus_rdata, i_address, 1'b0);
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			default: begin
				next_state = ST_INITIALIZE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpu_icache.sv
`default_nettype none

module cpu_icache import cpu_mem_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input  wire         i_clock,
	input  wire         i_rst,

	// Fetch side
	input  wire         i_request,
	input  wire addr_t  i_address,
	output logic        o_ready,
	output word_t       o_rdata,

	// Bus side, reads only
	output logic        o_bus_request,
	output addr_t       o_bus_address,
	input  wire word_t  i_bus_rdata,
	input  wire         i_bus_ready
);

	typedef enum logic [1:0] {
		ST_INITIALIZE,
		ST_IDLE,
		ST_LOOKUP,
		ST_REFILL
	} state_t;

	state_t state;
	state_t next_state;

	logic [INDEX_BITS-1:0] sweep_index;
	logic [INDEX_BITS-1:0] next_sweep_index;

	logic                  cache_we;
	logic [INDEX_BITS-1:0] cache_address;
	entry_t                cache_wdata;
	entry_t                cache_rdata;

	cache_bram #(
		.WIDTH      ($bits(entry_t)),
		.DEPTH_BITS (INDEX_BITS)
	) bram0 (
		.i_clock   (i_clock),
		.i_we      (cache_we),
		.i_address (cache_address),
		.i_wdata   (cache_wdata),
		.o_rdata   (cache_rdata)
	);

	logic hit;

	// Full word address compare, the index bits match by construction
	assign hit = cache_rdata[ENTRY_VALID_BIT] &&
		(entry_address(cache_rdata) == {i_address[31:2], 2'b00});

	always_ff @(posedge i_clock) begin
		if (i_rst) begin
			state <= ST_INITIALIZE;
			sweep_index <= '0;
		end else begin
			state <= next_state;
			sweep_index <= next_sweep_index;
		end
	end

	always_comb begin
		next_state = state;
		next_sweep_index = sweep_index;
		cache_we = 1'b0;
		cache_address = i_address[INDEX_BITS+1:2];
		cache_wdata = ENTRY_INVALID;
		o_ready = 1'b0;
		o_rdata = '0;
		o_bus_request = 1'b0;
		o_bus_address = '0;

		case (state)
			ST_INITIALIZE: begin
				cache_we = 1'b1;
				cache_address = sweep_index;
				next_sweep_index = sweep_index + 1'b1;
				if (sweep_index == '1) begin
					next_state = ST_IDLE;
				end
			end

			ST_IDLE: begin
				if (i_request) begin
					next_state = ST_LOOKUP;
				end
			end

			// Entry for i_address is on the RAM output now
			ST_LOOKUP: begin
				if (hit) begin
					o_rdata = entry_data(cache_rdata);
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end else begin
					next_state = ST_REFILL;
				end
			end

			ST_REFILL: begin
				o_bus_request = 1'b1;
				o_bus_address = i_address;
				o_rdata = i_bus_rdata;
				if (i_bus_ready) begin
					cache_we = 1'b1;
					cache_wdata = make_entry(i_bus_rdata, i_address, 1'b0);
					o_ready = 1'b1;
					next_state = ST_IDLE;
				end
			end

			default: begin
				next_state = ST_INITIALIZE;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpu_mem_pkg.sv
`default_nettype none

package cpu_mem_pkg;

	// ==========================================================================
	// Widths
	// ==========================================================================
	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [63:0] entry_t;

	// Entry layout: data on top, word address, dirty, valid
	localparam int ENTRY_VALID_BIT = 0;
	localparam int ENTRY_DIRTY_BIT = 1;
	localparam int ENTRY_ADDR_LSB  = 2;
	localparam int ENTRY_DATA_LSB  = 32;

	// Written everywhere by the sweep after reset
	localparam entry_t ENTRY_INVALID = '0;

	function automatic entry_t make_entry(word_t data, addr_t address, logic dirty);
		entry_t e;
		e = '0;
		e[ENTRY_DATA_LSB +: 32] = data;
		e[31:ENTRY_ADDR_LSB] = address[31:2];
		e[ENTRY_DIRTY_BIT] = dirty;
		e[ENTRY_VALID_BIT] = 1'b1;
		return e;
	endfunction

	function automatic word_t entry_data(entry_t e);
		return e[ENTRY_DATA_LSB +: 32];
	endfunction

	function automatic addr_t entry_address(entry_t e);
		return {e[31:ENTRY_ADDR_LSB], 2'b00};
	endfunction

endpackage

`default_nettype wire

// File: rtl/cpu_mem_top.sv
`default_nettype none

module cpu_mem_top import cpu_mem_pkg::*; #(
	parameter int INDEX_BITS = 4
) (
	input  wire         i_clock,
	input  wire         i_rst,

	// Data port
	input  wire         i_d_request,
	input  wire         i_d_rw,
	input  wire         i_d_flush,
	input  wire         i_d_cacheable,
	input  wire addr_t  i_d_address,
	input  wire word_t  i_d_wdata,
	output word_t       o_d_rdata,
	output logic        o_d_ready,

	// Fetch port
	input  wire         i_f_request,
	input  wire addr_t  i_f_address,
	output word_t       o_f_rdata,
	output logic        o_f_ready,

	// Memory bus
	output logic        o_bus_request,
	output logic        o_bus_rw,
	output addr_t       o_bus_address,
	output word_t       o_bus_wdata,
	input  wire word_t  i_bus_rdata,
	input  wire         i_bus_ready
);

	// Data cache to arbiter
	logic  dc_bus_request;
	logic  dc_bus_rw;
	addr_t dc_bus_address;
	word_t dc_bus_wdata;
	logic  dc_bus_ready;

	// Instruction cache to arbiter
	logic  ic_bus_request;
	addr_t ic_bus_address;
	logic  ic_bus_ready;

	cpu_dcache #(.INDEX_BITS(INDEX_BITS)) dcache0 (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(i_d_request), .i_rw(i_d_rw), .i_flush(i_d_flush),
		.i_cacheable(i_d_cacheable), .i_address(i_d_address), .i_wdata(i_d_wdata),
		.o_ready(o_d_ready), .o_rdata(o_d_rdata),
		.o_bus_request(dc_bus_request), .o_bus_rw(dc_bus_rw),
		.o_bus_address(dc_bus_address), .o_bus_wdata(dc_bus_wdata),
		.i_bus_rdata(i_bus_rdata), .i_bus_ready(dc_bus_ready)
	);

	cpu_icache #(.INDEX_BITS(INDEX_BITS)) icache0 (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_request(i_f_request), .i_address(i_f_address),
		.o_ready(o_f_ready), .o_rdata(o_f_rdata),
		.o_bus_request(ic_bus_request), .o_bus_address(ic_bus_address),
		.i_bus_rdata(i_bus_rdata), .i_bus_ready(ic_bus_ready)
	);

	cpu_bus_arbiter arbiter0 (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_d_request(dc_bus_request), .i_d_rw(dc_bus_rw),
		.i_d_address(dc_bus_address), .i_d_wdata(dc_bus_wdata), .o_d_ready(dc_bus_ready),
		.i_i_request(ic_bus_request), .i_i_address(ic_bus_address), .o_i_ready(ic_bus_ready),
		.o_bus_request(o_bus_request), .o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address), .o_bus_wdata(o_bus_wdata),
		.i_bus_ready(i_bus_ready)
	);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the cache subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_cpu_mem -f cpu_mem.f -o tb_cpu_mem
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/tb_cpu_mem)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// File: tb/cpu_mem_assert.sv
`default_nettype none

module cpu_mem_assert import cpu_mem_pkg::*; (
	input wire        i_clock,
	input wire        i_rst,
	input wire        i_bus_request,
	input wire        i_bus_rw,
	input wire addr_t i_bus_address,
	input wire        i_bus_ready,
	input wire        i_d_ready,
	input wire        i_f_ready
);

	timeunit 1ns;
	timeprecision 1ps;

	// Master holds its transfer until the memory answers
	// Fields may move in the ready cycle to chain a refill
	bus_hold: assert property (@(posedge i_clock) disable iff (i_rst)
		(i_bus_request && !i_bus_ready) |=>
			(i_bus_request && (i_bus_ready ||
				($stable(i_bus_address) && $stable(i_bus_rw)))))
		else $error("bus transfer changed before ready");

	reset_quiet: assert property (@(posedge i_clock)
		i_rst |-> (!i_d_ready && !i_f_ready && !i_bus_request))
		else $error("ready or bus request during reset");

	// Ready is a single-cycle strobe
	d_ready_strobe: assert property (@(posedge i_clock) disable iff (i_rst)
		i_d_ready |=> !i_d_ready)
		else $error("data ready high for two cycles");

endmodule

bind cpu_mem_top cpu_mem_assert assert0 (
	.i_clock(i_clock),
	.i_rst(i_rst),
	.i_bus_request(o_bus_request),
	.i_bus_rw(o_bus_rw),
	.i_bus_address(o_bus_address),
	.i_bus_ready(i_bus_ready),
	.i_d_ready(o_d_ready),
	.i_f_ready(o_f_ready)
);

`default_nettype wire

// File: tb/tb_cpu_mem.sv
`default_nettype none

module tb_cpu_mem import cpu_mem_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int INDEX_BITS = 4;
	localparam int TIMEOUT    = 200;

	typedef enum logic {PORT_DATA, PORT_FETCH} port_t;
	typedef enum logic [1:0] {OP_READ, OP_WRITE, OP_FLUSH} op_t;

	typedef struct {
		string name;
		port_t port;
		op_t   op;
		bit    cacheable;
		bit    fast;       // answer due in the second cycle
		bit    overlap;    // runs alongside the next entry
		addr_t address;
		word_t wdata;
		word_t expected;
	} stim_t;

	logic  i_clock = 1'b0;
	logic  i_rst;
	logic  i_d_request;
	logic  i_d_rw;
	logic  i_d_flush;
	logic  i_d_cacheable;
	addr_t i_d_address;
	word_t i_d_wdata;
	word_t o_d_rdata;
	logic  o_d_ready;
	logic  i_f_request;
	addr_t i_f_address;
	word_t o_f_rdata;
	logic  o_f_ready;
	logic  o_bus_request;
	logic  o_bus_rw;
	addr_t o_bus_address;
	word_t o_bus_wdata;
	word_t i_bus_rdata = '0;
	logic  i_bus_ready = 1'b0;

	int    seed = 32'h56ee;
	int    bus_delay = 0;
	word_t mem [addr_t];
	word_t ref_mem [addr_t];
	stim_t stim_q [$];
	int    tests_run = 0;
	int    tests_failed = 0;

	cpu_mem_top #(.INDEX_BITS(INDEX_BITS)) dut0 (
		.i_clock(i_clock), .i_rst(i_rst),
		.i_d_request(i_d_request), .i_d_rw(i_d_rw), .i_d_flush(i_d_flush),
		.i_d_cacheable(i_d_cacheable), .i_d_address(i_d_address), .i_d_wdata(i_d_wdata),
		.o_d_rdata(o_d_rdata), .o_d_ready(o_d_ready),
		.i_f_request(i_f_request), .i_f_address(i_f_address),
		.o_f_rdata(o_f_rdata), .o_f_ready(o_f_ready),
		.o_bus_request(o_bus_request), .o_bus_rw(o_bus_rw),
		.o_bus_address(o_bus_address), .o_bus_wdata(o_bus_wdata),
		.i_bus_rdata(i_bus_rdata), .i_bus_ready(i_bus_ready)
	);

	always #2 i_clock = ~i_clock;

	// =========================================================================
	// Memory model
	// =========================================================================
	// Untouched words follow the whole address
	function automatic word_t read_mem(addr_t address);
		if (mem.exists(address)) begin
			return mem[address];
		end
		return address ^ 32'h5a5a_a5a5;
	endfunction

	// One ready strobe per transfer, after 0 to 3 wait cycles
	always @(posedge i_clock) begin
		if (i_rst || i_bus_ready) begin
			i_bus_ready <= 1'b0;
		end else if (o_bus_request) begin
			if (bus_delay == 0) begin
				if (o_bus_rw) begin
					mem[o_bus_address] = o_bus_wdata;
				end else begin
					i_bus_rdata <= read_mem(o_bus_address);
				end
				i_bus_ready <= 1'b1;
				bus_delay = $unsigned($random(seed)) % 4;
			end else begin
				bus_delay = bus_delay - 1;
			end
		end
	end

	// Latest write to an address, else its first memory value
	function automatic word_t model_word(addr_t address);
		if (!ref_mem.exists(address)) begin
			if (!mem.exists(address)) begin
				mem[address] = $random(seed);
			end
			ref_mem[address] = mem[address];
		end
		return ref_mem[address];
	endfunction

	task automatic add_entry(input string name, input port_t port, input op_t op,
		input bit cacheable, input bit fast, input bit overlap,
		input addr_t address, input word_t wdata);
		stim_t e;
		e.name = name;
		e.port = port;
		e.op = op;
		e.cacheable = cacheable;
		e.fast = fast;
		e.overlap = overlap;
		e.address = address;
		e.wdata = wdata;
		e.expected = model_word(address);
		if (op == OP_WRITE) begin
			ref_mem[address] = wdata;
			e.expected = wdata;
		end
		stim_q.push_back(e);
	endtask

	task automatic build_table();
		// Write then read hit
		add_entry("wr_hit_a", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0010, 32'h1111_0001);
		add_entry("rd_hit_a", PORT_DATA, OP_READ, 1, 1, 0, 32'h0000_0010, '0);
		// Same index, two tags
		add_entry("wr_conf_a", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0100, 32'ha0a0_0001);
		add_entry("wr_conf_b", PORT_DATA, OP_WRITE, 1, 0, 0, 32'h0000_0140, 32'hb0b0_0001);
		add_entry("rd_conf_a", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0100, '0);
		add_entry("rd_conf_b", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0140, '0);
		add_entry("wr_conf_a2", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0100, 32'ha0a0_0002);
		add_entry("rd_conf_b2", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0140, '0);
		add_entry("rd_conf_a2", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0100, '0);
		// Pass-through
		add_entry("unc_wr", PORT_DATA, OP_WRITE, 0, 0, 0, 32'h0000_0300, 32'h3333_0003);
		add_entry("unc_rd", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0300, '0);
		add_entry("unc_rd_init", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0304, '0);
		// Dirty lines, flush, then read memory directly
		add_entry("fl_wr_0", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0200, 32'hf100_0000);
		add_entry("fl_wr_1", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0204, 32'hf100_0001);
		add_entry("fl_wr_2", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0208, 32'hf100_0002);
		add_entry("flush", PORT_DATA, OP_FLUSH, 1, 0, 0, 32'h0000_0000, '0);
		add_entry("fl_rd_0", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0200, '0);
		add_entry("fl_rd_1", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0204, '0);
		add_entry("fl_rd_2", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0208, '0);
		add_entry("fl_rd_10", PORT_DATA, OP_READ, 0, 0, 0, 32'h0000_0010, '0);
		// Fetches alongside data traffic
		add_entry("fetch_miss_0", PORT_FETCH, OP_READ, 1, 0, 1, 32'h0000_1000, '0);
		add_entry("dat_miss_0", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0240, '0);
		add_entry("fetch_hit_0", PORT_FETCH, OP_READ, 1, 1, 1, 32'h0000_1000, '0);
		add_entry("dat_wr_0", PORT_DATA, OP_WRITE, 1, 1, 0, 32'h0000_0280, 32'hd000_0280);
		add_entry("fetch_miss_1", PORT_FETCH, OP_READ, 1, 0, 1, 32'h0000_1004, '0);
		add_entry("dat_miss_1", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_02c0, '0);
		add_entry("fetch_hit_1", PORT_FETCH, OP_READ, 1, 1, 1, 32'h0000_1004, '0);
		add_entry("dat_rd_280", PORT_DATA, OP_READ, 1, 0, 0, 32'h0000_0280, '0);
		add_entry("fetch_miss_2", PORT_FETCH, OP_READ, 1, 0, 1, 32'h0000_1040, '0);
		add_entry("dat_rd_10", PORT_DATA, OP_READ, 1, 1, 0, 32'h0000_0010, '0);
		add_entry("fetch_again_0", PORT_FETCH, OP_READ, 1, 0, 0, 32'h0000_1000, '0);
	endtask

	// =========================================================================
	// Checks
	// =========================================================================
	task automatic check_word(input string name, input word_t expected, input word_t actual,
		inout bit failed);
		if (actual !== expected) begin
			$display("error %s: expected %h, actual %h", name, expected, actual);
			failed = 1'b1;
		end
	endtask

	task automatic check_addr(input string name, input addr_t expected, input addr_t actual,
		inout bit failed);
		if (actual !== expected) begin
			$display("error %s: bus address expected %h, actual %h", name, expected, actual);
			failed = 1'b1;
		end
	endtask

	task automatic check_latency(input string name, input int expected, input int actual,
		inout bit failed);
		if (actual != expected) begin
			$display("error %s: latency expected %0d, actual %0d", name, expected, actual);
			failed = 1'b1;
		end
	endtask

	// Sweep length is fixed by the index width
	task automatic wait_sweep();
		int n;
		n = 0;
		while (n < (1 << INDEX_BITS) + 2) begin
			@(posedge i_clock);
			n++;
		end
	endtask

	task automatic run_entry(input stim_t e);
		int    cycles;
		bit    seen;
		bit    failed;
		bit    addr_checked;
		word_t rdata;
		cycles = 0;
		seen = 1'b0;
		failed = 1'b0;
		addr_checked = 1'b0;
		rdata = '0;
		@(posedge i_clock);
		if (e.port == PORT_DATA) begin
			i_d_request   <= 1'b1;
			i_d_rw        <= (e.op == OP_WRITE);
			i_d_flush     <= (e.op == OP_FLUSH);
			i_d_cacheable <= e.cacheable;
			i_d_address   <= e.address;
			i_d_wdata     <= e.wdata;
		end else begin
			i_f_request <= 1'b1;
			i_f_address <= e.address;
		end
		while (!seen && cycles < TIMEOUT) begin
			@(negedge i_clock);
			cycles++;
			if (e.port == PORT_DATA) begin
				// Uncached access puts the caller's address on the bus
				if (!e.cacheable && o_bus_request && !addr_checked) begin
					check_addr(e.name, e.address, o_bus_address, failed);
					addr_checked = 1'b1;
				end
				seen = o_d_ready;
				rdata = o_d_rdata;
			end else begin
				seen = o_f_ready;
				rdata = o_f_rdata;
			end
		end
		@(posedge i_clock);
		if (e.port == PORT_DATA) begin
			i_d_request <= 1'b0;
			i_d_flush   <= 1'b0;
		end else begin
			i_f_request <= 1'b0;
		end
		if (!seen) begin
			$display("%s: the DUT gave no ready within %0d cycles", e.name, TIMEOUT);
			failed = 1'b1;
		end else begin
			if (e.op == OP_READ) begin
				check_word(e.name, e.expected, rdata, failed);
			end
			if (e.fast) begin
				check_latency(e.name, 2, cycles, failed);
			end
		end
		tests_run++;
		if (failed) begin
			tests_failed++;
			$display("%s: FAIL after %0d cycles", e.name, cycles);
		end else begin
			$display("%s: ok after %0d cycles", e.name, cycles);
		end
	endtask

	initial begin
		int i;
		i_rst = 1'b1;
		i_d_request = 1'b0;
		i_d_rw = 1'b0;
		i_d_flush = 1'b0;
		i_d_cacheable = 1'b0;
		i_d_address = '0;
		i_d_wdata = '0;
		i_f_request = 1'b0;
		i_f_address = '0;
		build_table();
		repeat (16) @(posedge i_clock);
		i_rst <= 1'b0;
		wait_sweep();
		i = 0;
		while (i < stim_q.size()) begin
			if (stim_q[i].overlap && i + 1 < stim_q.size()) begin
				fork
					run_entry(stim_q[i]);
					run_entry(stim_q[i + 1]);
				join
				i += 2;
			end else begin
				run_entry(stim_q[i]);
				i++;
			end
		end
		$display("%0d tests run, %0d failed", tests_run, tests_failed);
		if (tests_failed == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
